// File: flist.f
source/dna_pkg.sv
source/array_pkg.sv
source/nt_decode.sv
source/array_ctrl.sv
source/score_pe.sv
source/max_collect.sv
source/align_top.sv
tests/align_check.sv
tests/align_assert.sv
tests/align_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := align_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG) || ! grep -q "all tests passed" $(LOG); then \
		echo "simulation FAILED"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/align_tb.sv
// testbench for the alignment array: memory models, seeded random jobs and a
// reference model of the affine local alignment that sets the expected cell
module align_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import array_pkg::*;

  localparam int TIMEOUT  = 4000;
  localparam int NUM_JOBS = 40;
  localparam int NEG      = int'(NEG_INF);

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       start;
  score_param_t               params;
  align_mode_t                mode;
  logic [REF_LEN_WIDTH-1:0]   ref_length;
  logic [QUERY_LEN_WIDTH-1:0] query_length;
  logic [7:0]                 ref_data = 8'h00;
  logic [7:0]                 query_data = 8'h00;
  logic [REF_LEN_WIDTH-1:0]   ref_rd_addr;
  logic [QUERY_LEN_WIDTH-1:0] query_rd_addr;
  logic                       done;
  best_t                      best;
  logic [7:0]                 ref_mem [1 << REF_LEN_WIDTH];
  logic [7:0]                 query_mem [1 << QUERY_LEN_WIDTH];
  logic [REF_LEN_WIDTH-1:0]   ref_addr_q;
  logic [QUERY_LEN_WIDTH-1:0] query_addr_q;
  best_t                      exp_best;
  int                         jobs_started;
  int                         n_done;
  int                         n_bad;
  int                         n_err;
  bit                         timed_out;

  always #2 clk = ~clk;

  // address taken on the rising edge, data out half a cycle later
  always @(posedge clk) begin
    ref_addr_q   <= ref_rd_addr;
    query_addr_q <= query_rd_addr;
  end

  always @(negedge clk) begin
    ref_data   <= ref_mem[ref_addr_q];
    query_data <= query_mem[query_addr_q];
  end

  align_top i_align_top (.clk, .rst, .start, .params, .mode, .ref_length, .query_length,
                         .ref_data, .query_data, .ref_rd_addr, .query_rd_addr, .done, .best);

  align_check i_check (.clk, .done, .best, .exp_best, .exp_jobs(jobs_started),
                       .n_done, .n_bad, .n_err);

  function automatic int base_code(logic [7:0] c, bit complement);
    int code;
    case (c)
      "A", "a": code = 0;
      "C", "c": code = 1;
      "G", "g": code = 2;
      "T", "t": code = 3;
      default:  code = 4;  // N
    endcase
    if (complement && code < 4) code = 3 - code;  // A<->T, C<->G
    return code;
  endfunction

  function automatic int max_int(int a, int b);
    return (a > b) ? a : b;
  endfunction

  function automatic best_t align_model(int ql, int rl, align_mode_t m, score_param_t p);
    int    q [NUM_PE+1];
    int    v_left [NUM_PE+1];  // column j-1
    int    v_cur [NUM_PE+1];
    int    e [NUM_PE+1];
    int    f;
    int    s;
    int    v;
    int    rc;
    best_t res;
    res = '0;
    v_left[0] = 0;
    v_cur[0] = 0;
    for (int i = 1; i <= ql; i++) begin
      q[i] = base_code(query_mem[m.reverse_query ? ql - i : i - 1], m.complement_query);
      v_left[i] = 0;
      e[i] = NEG;
    end
    for (int j = 1; j <= rl; j++) begin
      rc = base_code(ref_mem[m.reverse_ref ? rl - j : j - 1], m.complement_ref);
      f = NEG;
      for (int i = 1; i <= ql; i++) begin
        e[i] = max_int(v_left[i] + int'(p.gap_open), e[i] + int'(p.gap_extend));
        f = max_int(v_cur[i-1] + int'(p.gap_open), f + int'(p.gap_extend));
        if (q[i] == 4 || rc == 4) s = int'(p.n_score);
        else if (q[i] == rc) s = int'(p.match);
        else s = int'(p.mismatch);
        v = max_int(max_int(0, e[i]), max_int(f, v_left[i-1] + s));
        v_cur[i] = v;
        if (v > int'(res.score)) begin  // scan order gives the tie rule
          res = '{score: score_t'(v), ref_pos: REF_LEN_WIDTH'(j), query_pos: QUERY_LEN_WIDTH'(i)};
        end
      end
      v_left = v_cur;
    end
    return res;
  endfunction

  function automatic logic [7:0] rand_char(bit mixed);
    string pool;
    pool = mixed ? "ACGTacgtNnRX-" : "ACGT";
    return pool[$urandom_range(0, pool.len() - 1)];
  endfunction

  task automatic run_job(input int ql, input int rl, input align_mode_t m, input bit mixed,
                         input bit same, input bit busy_start);
    int cycles;
    bit seen;
    if (timed_out) return;
    @(negedge clk);
    for (int i = 0; i < ql; i++) query_mem[i] = rand_char(mixed);
    for (int j = 0; j < rl; j++) ref_mem[j] = same ? query_mem[j] : rand_char(mixed);
    params.match      = score_t'($urandom_range(1, 12));
    params.mismatch   = score_t'(-int'($urandom_range(0, 10)));
    params.n_score    = score_t'(int'($urandom_range(0, 10)) - 5);
    params.gap_open   = score_t'(-int'($urandom_range(1, 12)));
    params.gap_extend = score_t'(-int'($urandom_range(1, 6)));
    mode = m;
    query_length = QUERY_LEN_WIDTH'(ql);
    ref_length = REF_LEN_WIDTH'(rl);
    exp_best = align_model(ql, rl, m, params);
    if (same) begin  // identical strings peak at the end of the diagonal
      exp_best = '{score: score_t'(ql * int'(params.match)), ref_pos: REF_LEN_WIDTH'(ql),
                   query_pos: QUERY_LEN_WIDTH'(ql)};
    end
    start = 1'b1;
    jobs_started++;
    @(negedge clk);
    start = 1'b0;
    if (busy_start) begin
      repeat (3) @(negedge clk);
      start = 1'b1;
      mode = align_mode_t'(~m);
      ref_length = REF_LEN_WIDTH'(rl % 7 + 1);
      @(negedge clk);
      start = 1'b0;
    end
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < TIMEOUT) begin
      @(negedge clk);
      seen = done;
      cycles++;
    end
    if (!seen) begin
      $display("timed out after %0d cycles waiting for done on job %0d", TIMEOUT, jobs_started);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    int ql;
    int rl;
    void'($urandom(48851));
    rst = 1'b1;
    start = 1'b0;
    params = '0;
    mode = '0;
    ref_length = '0;
    query_length = '0;
    exp_best = '0;
    jobs_started = 0;
    timed_out = 1'b0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    run_job(1, 1, '0, 1'b0, 1'b0, 1'b0);
    run_job(NUM_PE, 1, '0, 1'b0, 1'b0, 1'b0);
    run_job(1, 57, '0, 1'b1, 1'b0, 1'b0);
    run_job(NUM_PE, 1023, '0, 1'b0, 1'b0, 1'b0);
    run_job(NUM_PE, NUM_PE, '0, 1'b0, 1'b1, 1'b0);
    run_job(9, 9, '0, 1'b0, 1'b1, 1'b0);
    run_job(12, 40, '0, 1'b0, 1'b0, 1'b1);  // second start lands mid job
    for (int n = 0; n < NUM_JOBS; n++) begin
      ql = $urandom_range(1, NUM_PE);
      rl = $urandom_range(1, 200);
      run_job(ql, rl, align_mode_t'($urandom_range(0, 15)), $urandom_range(0, 3) == 0,
              1'b0, n % 10 == 5);
    end
    repeat (5) @(negedge clk);  // room for a stray done
    $display("%0d jobs started, %0d results, %0d mismatched, %0d errors",
             jobs_started, n_done, n_bad, n_err);
    if (!timed_out && n_err == 0 && n_bad == 0 && n_done == jobs_started) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: tests/align_assert.sv
// protocol checks on the alignment top level
// attached to align_top by the bind at the bottom
module align_assert (
  input logic                         clk,
  input logic                         rst,
  input logic                         done,
  input logic [array_pkg::NUM_PE-1:0] load_sel,
  input array_pkg::ctrl_state_e       state,
  input logic                         wave_valid
);
  timeunit 1ns;
  timeprecision 100ps;
  import array_pkg::*;

  done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done high on two cycles in a row");

  // registers are cleared by the first reset edge and stay low after it
  reset_quiet: assert property (@(posedge clk) (rst && $past(rst)) |-> (!done && load_sel == '0))
    else $error("done or load_sel active during reset");

  load_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(load_sel))
    else $error("load_sel has more than one bit set");

  // the drain must have emptied the whole chain before the FSM is idle again
  idle_no_wave: assert property (@(posedge clk) disable iff (rst) (state == IDLE) |-> !wave_valid)
    else $error("wave still in the element chain while idle");

endmodule

bind align_top align_assert i_assert (
  .clk, .rst, .done, .load_sel,
  .state      (i_ctrl.state),
  .wave_valid (wave_chain[array_pkg::NUM_PE].valid)
);

// File: tests/align_check.sv
// compares each alignment result with the expected cell from the model
// prints one line per finished job and hands the counts back to the testbench
module align_check (
  input  logic             clk,
  input  logic             done,
  input  array_pkg::best_t best,
  input  array_pkg::best_t exp_best,
  input  int               exp_jobs,  // jobs started so far
  output int               n_done,
  output int               n_bad,
  output int               n_err
);
  timeunit 1ns;
  timeprecision 100ps;
  import array_pkg::*;

  int done_cnt = 0;
  int bad_cnt  = 0;
  int err_cnt  = 0;

  task automatic compare_field(input string name, input int expv, input int actv,
                               inout int errs);
    if (expv != actv) begin
      $display("Error at %0t: %s expected %0d got %0d", $time, name, expv, actv);
      errs++;
    end
  endtask

  // best is held for the whole done cycle, so sample mid cycle
  always @(negedge clk) begin : sample
    int errs;
    if (done) begin
      errs = 0;
      done_cnt++;
      if (done_cnt > exp_jobs) begin
        $display("done pulsed at %0t with no job outstanding", $time);
        errs++;
      end
      compare_field("best.score", int'(exp_best.score), int'(best.score), errs);
      compare_field("best.ref_pos", int'(exp_best.ref_pos), int'(best.ref_pos), errs);
      compare_field("best.query_pos", int'(exp_best.query_pos), int'(best.query_pos), errs);
      if (errs == 0) begin
        $display("job %0d ok: score %0d at ref %0d, query %0d", done_cnt,
                 int'(best.score), int'(best.ref_pos), int'(best.query_pos));
      end else begin
        $display("job %0d mismatch", done_cnt);
        bad_cnt++;
      end
      err_cnt += errs;
    end
  end

  assign n_done = done_cnt;
  assign n_bad  = bad_cnt;
  assign n_err  = err_cnt;

endmodule

// File: source/align_top.sv
// local alignment engine: decoders, sequencer, systolic element chain and
// the max tree; memories sit outside and answer one cycle after the address
module align_top (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 start,
  input  array_pkg::score_param_t              params,
  input  array_pkg::align_mode_t               mode,
  input  logic [array_pkg::REF_LEN_WIDTH-1:0]   ref_length,
  input  logic [array_pkg::QUERY_LEN_WIDTH-1:0] query_length,
  input  logic [7:0]                           ref_data,
  input  logic [7:0]                           query_data,
  output logic [array_pkg::REF_LEN_WIDTH-1:0]   ref_rd_addr,
  output logic [array_pkg::QUERY_LEN_WIDTH-1:0] query_rd_addr,
  output logic                                 done,
  output array_pkg::best_t                     best
);
  import array_pkg::*;
  import dna_pkg::*;

  nt_e                    ref_nt;
  nt_e                    query_nt;
  logic                   complement_ref;
  logic                   complement_query;
  logic [NUM_PE-1:0]      load_sel;
  wave_t                  wave_chain [NUM_PE+1];  // entry k feeds element k
  best_t [NUM_PE-1:0]     pe_best;
  logic                   collect;
  logic                   best_valid;

  nt_decode i_ref_dec (.ascii(ref_data), .complement(complement_ref), .nt(ref_nt));

  nt_decode i_query_dec (.ascii(query_data), .complement(complement_query), .nt(query_nt));

  array_ctrl i_ctrl (
    .clk, .rst, .start, .ref_length, .query_length, .mode, .ref_nt, .best_valid,
    .ref_rd_addr, .query_rd_addr, .load_sel,
    .ref_wave         (wave_chain[0]),
    .complement_ref, .complement_query, .collect, .done
  );

  for (genvar k = 0; k < NUM_PE; k++) begin : g_pe
    score_pe #(.PE_INDEX(k)) i_pe (
      .clk,
      .rst,
      .params,
      .load     (load_sel[k]),
      .query_nt (query_nt),  // broadcast, load_sel picks the taker
      .wave_in  (wave_chain[k]),
      .wave_out (wave_chain[k+1]),
      .best     (pe_best[k])
    );
  end

  max_collect i_collect (.clk, .rst, .collect, .pe_best, .best, .best_valid);

endmodule

// File: source/max_collect.sv
// registered pairwise max tree over the per-element best cells
// ties go to the lower reference position, then the lower query position
module max_collect (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    collect,
  input  array_pkg::best_t [array_pkg::NUM_PE-1:0] pe_best,
  output array_pkg::best_t                        best,
  output logic                                    best_valid
);
  import array_pkg::*;

  logic [COLLECT_LAT-1:0] vld_q;     // bit l set when level l holds a fresh result
  logic [COLLECT_LAT-1:0] level_en;

  function automatic best_t pick(best_t a, best_t b);
    if (a.score != b.score) return (a.score > b.score) ? a : b;
    if (a.ref_pos != b.ref_pos) return (a.ref_pos < b.ref_pos) ? a : b;
    return (a.query_pos <= b.query_pos) ? a : b;
  endfunction

  assign level_en = {vld_q[COLLECT_LAT-2:0], collect};

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= level_en;
    end
  end

  for (genvar l = 0; l < COLLECT_LAT; l++) begin : g_level
    for (genvar n = 0; n < (NUM_PE >> (l + 1)); n++) begin : g_node
      best_t a;
      best_t b;
      best_t q;

      if (l == 0) begin : g_leaf
        assign a = pe_best[2*n];
        assign b = pe_best[2*n+1];
      end else begin : g_inner
        assign a = g_level[l-1].g_node[2*n].q;
        assign b = g_level[l-1].g_node[2*n+1].q;
      end

      // each level holds until its inputs are refreshed
      always_ff @(posedge clk) begin
        if (level_en[l]) begin
          q <= pick(a, b);
        end
      end
    end
  end

  assign best       = g_level[COLLECT_LAT-1].g_node[0].q;
  assign best_valid = vld_q[COLLECT_LAT-1];

endmodule

// File: source/score_pe.sv
// one processing element: holds a query character and evaluates the
// affine-gap local recurrence for every reference column passing through
module score_pe #(
  parameter int PE_INDEX = 0  // query row is PE_INDEX + 1
) (
  input  logic                    clk,
  input  logic                    rst,
  input  array_pkg::score_param_t params,
  input  logic                    load,
  input  dna_pkg::nt_e            query_nt,
  input  array_pkg::wave_t        wave_in,
  output array_pkg::wave_t        wave_out,
  output array_pkg::best_t        best
);
  import array_pkg::*;
  import dna_pkg::*;

  typedef logic signed [PE_WIDTH+1:0] wide_t;

  score_param_t             params_q;
  nt_e                      q_nt;
  logic                     loaded;  // loaded for a job whose stream has not arrived yet
  logic                     active;
  score_t                   e_row;   // E(i, j-1)
  score_t                   v_q;     // doubles as V(i, j-1) for the next column
  score_t                   f_q;
  score_t                   v_prev_q;
  nt_e                      nt_q;
  logic [REF_LEN_WIDTH-1:0] pos_q;
  logic                     valid_q;
  best_t                    best_q;
  score_t                   sub;
  score_t                   e_new;
  score_t                   f_new;
  score_t                   diag;
  score_t                   v_new;

  function automatic score_t sat_add(score_t a, score_t b);
    wide_t sum;
    sum = wide_t'(a) + wide_t'(b);
    if (sum < wide_t'(NEG_INF)) return NEG_INF;
    if (sum > wide_t'(SCORE_MAX)) return SCORE_MAX;
    return score_t'(sum);
  endfunction

  function automatic score_t max2(score_t a, score_t b);
    return (a > b) ? a : b;
  endfunction

  always_comb begin
    if (q_nt == NT_N || wave_in.nt == NT_N) begin
      sub = params_q.n_score;
    end else if (q_nt == wave_in.nt) begin
      sub = params_q.match;
    end else begin
      sub = params_q.mismatch;
    end
    e_new = max2(sat_add(v_q, params_q.gap_open), sat_add(e_row, params_q.gap_extend));
    f_new = max2(sat_add(wave_in.v, params_q.gap_open), sat_add(wave_in.e, params_q.gap_extend));
    diag  = sat_add(wave_in.v_prev, sub);
    v_new = max2(max2(e_new, f_new), max2(diag, '0));  // local, clamp at zero
  end

  // first column of a job decides whether this row takes part
  always_ff @(posedge clk) begin
    if (rst) begin
      loaded  <= 1'b0;
      active  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= wave_in.valid;
      if (load) begin
        loaded <= 1'b1;
      end else if (wave_in.valid && wave_in.ref_pos == REF_LEN_WIDTH'(1)) begin
        active <= loaded;
        loaded <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      params_q <= params;
      q_nt     <= query_nt;
      e_row    <= NEG_INF;  // column zero boundary
      v_q      <= '0;
      best_q   <= '0;
    end else if (wave_in.valid) begin
      v_q      <= v_new;
      f_q      <= f_new;
      v_prev_q <= v_q;
      nt_q     <= wave_in.nt;
      pos_q    <= wave_in.ref_pos;
      e_row    <= e_new;
      if (v_new > best_q.score) begin  // strict, earliest column wins a tie
        best_q <= '{score: v_new, ref_pos: wave_in.ref_pos,
                    query_pos: QUERY_LEN_WIDTH'(PE_INDEX + 1)};
      end
    end
  end

  assign wave_out = '{v: v_q, e: f_q, v_prev: v_prev_q, nt: nt_q, ref_pos: pos_q, valid: valid_q};

  assign best = active ? best_q : '{score: NEG_INF, ref_pos: '0, query_pos: '0};

endmodule

// File: source/array_ctrl.sv
// job sequencer for the array: query load, reference stream, drain and reduce
// drives both memory read addresses and feeds the head of the element chain
module array_ctrl (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 start,
  input  logic [array_pkg::REF_LEN_WIDTH-1:0]   ref_length,
  input  logic [array_pkg::QUERY_LEN_WIDTH-1:0] query_length,
  input  array_pkg::align_mode_t               mode,
  input  dna_pkg::nt_e                         ref_nt,
  input  logic                                 best_valid,
  output logic [array_pkg::REF_LEN_WIDTH-1:0]   ref_rd_addr,
  output logic [array_pkg::QUERY_LEN_WIDTH-1:0] query_rd_addr,
  output logic [array_pkg::NUM_PE-1:0]          load_sel,
  output array_pkg::wave_t                     ref_wave,
  output logic                                 complement_ref,
  output logic                                 complement_query,
  output logic                                 collect,
  output logic                                 done
);
  import array_pkg::*;

  ctrl_state_e                state;
  logic [REF_LEN_WIDTH-1:0]   cnt;  // phase counter, shared by all phases
  logic [REF_LEN_WIDTH-1:0]   ref_len_q;
  logic [QUERY_LEN_WIDTH-1:0] query_len_q;
  align_mode_t                mode_q;
  logic                       last_query;
  logic                       last_ref;
  logic                       last_drain;

  assign last_query = (cnt == REF_LEN_WIDTH'(query_len_q));
  assign last_ref   = (cnt == ref_len_q);
  assign last_drain = (cnt == REF_LEN_WIDTH'(NUM_PE - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      cnt      <= '0;
      load_sel <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            ref_len_q     <= ref_length;
            query_len_q   <= query_length;
            mode_q        <= mode;
            query_rd_addr <= mode.reverse_query ? query_length - 1'b1 : '0;
            cnt           <= '0;
            load_sel      <= '0;
            state         <= LOAD_QUERY;
          end
        end

        LOAD_QUERY: begin
          // data lags the address by a cycle, so the strobe lags too
          if (last_query) begin
            load_sel    <= '0;
            cnt         <= '0;
            ref_rd_addr <= mode_q.reverse_ref ? ref_len_q - 1'b1 : '0;
            state       <= STREAM_REF;
          end else begin
            load_sel      <= (cnt == '0) ? {{(NUM_PE-1){1'b0}}, 1'b1} : load_sel << 1;
            cnt           <= cnt + 1'b1;
            query_rd_addr <= mode_q.reverse_query ? query_rd_addr - 1'b1
                                                  : query_rd_addr + 1'b1;
          end
        end

        STREAM_REF: begin
          if (last_ref) begin
            cnt   <= '0;
            state <= DRAIN;
          end else begin
            cnt         <= cnt + 1'b1;
            ref_rd_addr <= mode_q.reverse_ref ? ref_rd_addr - 1'b1 : ref_rd_addr + 1'b1;
          end
        end

        DRAIN: begin
          // last column needs NUM_PE cycles to clear the chain
          if (last_drain) begin
            cnt   <= '0;
            state <= REDUCE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        REDUCE: begin
          if (best_valid) begin
            state <= DONE;
          end
        end

        DONE: state <= IDLE;

        default: state <= IDLE;
      endcase
    end
  end

  // row zero of the matrix: V = 0, gap = -inf
  assign ref_wave = '{
    v:       '0,
    e:       NEG_INF,
    v_prev:  '0,
    nt:      ref_nt,
    ref_pos: cnt,  // 1-based once data is valid
    valid:   (state == STREAM_REF) && (cnt != '0)
  };

  assign complement_ref   = mode_q.complement_ref;
  assign complement_query = mode_q.complement_query;
  assign collect          = (state == DRAIN) && last_drain;
  assign done             = (state == DONE);

endmodule

// File: source/nt_decode.sv
// combinational ASCII to nucleotide decode with optional complement
// case insensitive, anything outside ACGT becomes N
module nt_decode (
  input  logic [7:0]   ascii,
  input  logic         complement,
  output dna_pkg::nt_e nt
);
  import dna_pkg::*;

  logic [7:0] folded;
  nt_e        base;

  assign folded = ascii | ASCII_CASE_BIT;  // only 'A'/'a' etc can land on a letter code

  always_comb begin
    case (folded)
      ASCII_A: base = NT_A;
      ASCII_C: base = NT_C;
      ASCII_G: base = NT_G;
      ASCII_T: base = NT_T;
      default: base = NT_N;
    endcase
  end

  always_comb begin
    if (!complement) begin
      nt = base;
    end else begin
      case (base)
        NT_A:    nt = NT_T;
        NT_T:    nt = NT_A;
        NT_C:    nt = NT_G;
        NT_G:    nt = NT_C;
        default: nt = NT_N;
      endcase
    end
  end

endmodule

// File: source/array_pkg.sv
// sizes, score types and the structs shared by the alignment array
// the wave struct is what one element hands to the next each cycle
package array_pkg;

  localparam int NUM_PE          = 16;
  localparam int COLLECT_LAT     = $clog2(NUM_PE);  // one tree level per cycle
  localparam int REF_LEN_WIDTH   = 10;
  localparam int QUERY_LEN_WIDTH = 5;
  localparam int PE_WIDTH        = 10;

  typedef logic signed [PE_WIDTH-1:0] score_t;

  localparam score_t NEG_INF   = {1'b1, {(PE_WIDTH-1){1'b0}}};
  localparam score_t SCORE_MAX = {1'b0, {(PE_WIDTH-1){1'b1}}};

  typedef struct packed {
    score_t match;
    score_t mismatch;
    score_t n_score;
    score_t gap_open;    // cost of the first gap character
    score_t gap_extend;  // cost of each further one
  } score_param_t;

  typedef struct packed {
    logic reverse_ref;
    logic reverse_query;
    logic complement_ref;
    logic complement_query;
  } align_mode_t;

  typedef struct packed {
    score_t                   v;       // V of the sending row at this column
    score_t                   e;       // vertical gap score of the sending row
    score_t                   v_prev;  // V of the sending row one column back
    dna_pkg::nt_e             nt;
    logic [REF_LEN_WIDTH-1:0] ref_pos;
    logic                     valid;
  } wave_t;

  typedef struct packed {
    score_t                     score;
    logic [REF_LEN_WIDTH-1:0]   ref_pos;
    logic [QUERY_LEN_WIDTH-1:0] query_pos;
  } best_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_QUERY,
    STREAM_REF,
    DRAIN,
    REDUCE,
    DONE
  } ctrl_state_e;

endpackage

// File: source/dna_pkg.sv
// nucleotide encoding and the ASCII codes the decoders match against
// imported by every block that carries nucleotides
package dna_pkg;

  typedef enum logic [2:0] {
    NT_A,
    NT_C,
    NT_G,
    NT_T,
    NT_N  // anything that is not ACGT
  } nt_e;

  // lower case codes; upper case folds onto these by setting the case bit
  localparam logic [7:0] ASCII_CASE_BIT = 8'h20;
  localparam logic [7:0] ASCII_A = 8'h61;
  localparam logic [7:0] ASCII_C = 8'h63;
  localparam logic [7:0] ASCII_G = 8'h67;
  localparam logic [7:0] ASCII_T = 8'h74;

endpackage
